// File: Bender.yml
package:
  name: cpu

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cpu_pkg.sv
      - rtl/iq_if.sv
      - rtl/ifetch.sv
      - rtl/inst_queue.sv
      - rtl/exec_unit.sv
      - rtl/cpu.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/tb_clock.sv
      - tests/cpu_asserts.sv
      - tests/cpu_tb.sv

// File: cpu.f
+incdir+rtl
rtl/cpu_pkg.sv
rtl/iq_if.sv
rtl/ifetch.sv
rtl/inst_queue.sv
rtl/exec_unit.sv
rtl/cpu.sv
tests/tb_clock.sv
tests/cpu_asserts.sv
tests/cpu_tb.sv

// File: rtl/cpu.sv
/* top level of the in-order slice
   fetch feeds the queue, the queue feeds execute, memory and debug are plain ports */
`timescale 1ns/1ns
`default_nettype none

module cpu (
  input  wire        clk_in,
  input  wire        i_rst_n,
  input  wire        i_rdy,       // freezes the core while low
  input  wire [7:0]  i_mem_din,   // read data one cycle after o_mem_a
  input  wire [4:0]  i_dbg_sel,
  output wire [31:0] o_mem_a,
  output wire [31:0] o_now_pc,    // pc of the last retired instruction
  output wire [31:0] o_dbgreg_dout
);

  iq_if fetch_q ();
  iq_if issue_q ();

  ifetch u_ifetch (
    .clk_in    (clk_in),
    .i_rst_n   (i_rst_n),
    .i_rdy     (i_rdy),
    .i_mem_din (i_mem_din),
    .o_mem_a   (o_mem_a),
    .q         (fetch_q)
  );

  inst_queue u_queue (
    .clk_in  (clk_in),
    .i_rst_n (i_rst_n),
    .i_rdy   (i_rdy),
    .wr      (fetch_q),
    .rd      (issue_q)
  );

  exec_unit u_exec (
    .clk_in        (clk_in),
    .i_rst_n       (i_rst_n),
    .i_rdy         (i_rdy),
    .i_dbg_sel     (i_dbg_sel),
    .q             (issue_q),
    .o_now_pc      (o_now_pc),
    .o_dbgreg_dout (o_dbgreg_dout)
  );

endmodule

`default_nettype wire

// File: rtl/cpu_pkg.sv
/* shared types for the cpu slice, referenced by scoped name */
`default_nettype none

package cpu_pkg;

  // one state per byte lane of the word being assembled, then hand-off
  typedef enum logic [2:0] {
    FS_B0,
    FS_B1,
    FS_B2,
    FS_B3,
    FS_PUSH
  } fetch_state_e;

  typedef enum logic [3:0] {
    OP_LUI,
    OP_ADDI,
    OP_XORI,
    OP_ORI,
    OP_ANDI,
    OP_ADD,
    OP_SUB,
    OP_XOR,
    OP_OR,
    OP_AND,
    OP_HALT, // all-zero word
    OP_NOP   // anything not decoded
  } op_e;

endpackage

`default_nettype wire

// File: rtl/cpu_settings.svh
/* build-time constants for the cpu slice
   include wherever queue depth, memory bounds or the reset pc are needed */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// instruction queue entries as a power of two
`define CPU_IQ_DEPTH 4

// first byte address past the end of the 128KB memory
`define CPU_MEM_LIMIT 32'h0002_0000

`define CPU_RESET_PC 32'h0000_0000 // first fetch address

`endif

// File: rtl/exec_unit.sv
/* decode, register file and ALU for the kept RV32I subset
   retires one queued instruction per enabled cycle until a halt word */
`timescale 1ns/1ns
`default_nettype none

module exec_unit (
  input  logic        clk_in,
  input  logic        i_rst_n,
  input  logic        i_rdy,
  input  logic [4:0]  i_dbg_sel,
  iq_if.dst           q,
  output logic [31:0] o_now_pc,
  output logic [31:0] o_dbgreg_dout
);

  logic [31:0] regs [32];
  cpu_pkg::op_e op;
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [4:0]  rd;
  logic [31:0] imm_i;
  logic [31:0] imm_u;
  logic [31:0] rs1_v;
  logic [31:0] rs2_v;
  logic [31:0] result;
  logic        halted;
  logic        pop;
  logic        wr_en;

  assign opcode = q.instr[6:0];
  assign funct3 = q.instr[14:12];
  assign funct7 = q.instr[31:25];
  assign rd     = q.instr[11:7];
  assign imm_i  = {{20{q.instr[31]}}, q.instr[31:20]};
  assign imm_u  = {q.instr[31:12], 12'b0};
  assign rs1_v  = regs[q.instr[19:15]];
  assign rs2_v  = regs[q.instr[24:20]];

  always_comb begin
    op = cpu_pkg::OP_NOP;
    if (q.instr == 32'd0) begin
      op = cpu_pkg::OP_HALT;
    end else if (opcode == 7'b0110111) begin
      op = cpu_pkg::OP_LUI;
    end else if (opcode == 7'b0010011) begin // op-imm
      case (funct3)
        3'b000: op = cpu_pkg::OP_ADDI;
        3'b100: op = cpu_pkg::OP_XORI;
        3'b110: op = cpu_pkg::OP_ORI;
        3'b111: op = cpu_pkg::OP_ANDI;
        default: op = cpu_pkg::OP_NOP;
      endcase
    end else if (opcode == 7'b0110011 && funct7 == 7'b0100000) begin
      if (funct3 == 3'b000) begin
        op = cpu_pkg::OP_SUB;
      end
    end else if (opcode == 7'b0110011 && funct7 == 7'b0000000) begin
      case (funct3)
        3'b000: op = cpu_pkg::OP_ADD;
        3'b100: op = cpu_pkg::OP_XOR;
        3'b110: op = cpu_pkg::OP_OR;
        3'b111: op = cpu_pkg::OP_AND;
        default: op = cpu_pkg::OP_NOP;
      endcase
    end
  end

  always_comb begin
    case (op)
      cpu_pkg::OP_LUI:  result = imm_u;
      cpu_pkg::OP_ADDI: result = rs1_v + imm_i;
      cpu_pkg::OP_XORI: result = rs1_v ^ imm_i;
      cpu_pkg::OP_ORI:  result = rs1_v | imm_i;
      cpu_pkg::OP_ANDI: result = rs1_v & imm_i;
      cpu_pkg::OP_ADD:  result = rs1_v + rs2_v;
      cpu_pkg::OP_SUB:  result = rs1_v - rs2_v;
      cpu_pkg::OP_XOR:  result = rs1_v ^ rs2_v;
      cpu_pkg::OP_OR:   result = rs1_v | rs2_v;
      cpu_pkg::OP_AND:  result = rs1_v & rs2_v;
      default:          result = 32'd0;
    endcase
  end

  assign q.ready = !halted;
  assign pop     = q.valid && q.ready && i_rdy;
  assign wr_en   = (op != cpu_pkg::OP_HALT) && (op != cpu_pkg::OP_NOP) && (rd != 5'd0);

  always_ff @(posedge clk_in) begin
    if (!i_rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'd0;
      end
      halted   <= 1'b0;
      o_now_pc <= 32'd0;
    end else if (pop) begin
      if (op == cpu_pkg::OP_HALT) begin
        halted <= 1'b1; // sticky so the queue backs up behind it
      end else begin
        o_now_pc <= q.pc;
      end
      if (wr_en) begin
        regs[rd] <= result; // x0 never written
      end
    end
  end

  assign o_dbgreg_dout = regs[i_dbg_sel];

endmodule

`default_nettype wire

// File: rtl/ifetch.sv
/* byte-serial instruction fetch, one address per enabled cycle
   assembles little-endian words and offers them on the queue link */
`include "cpu_settings.svh"
`timescale 1ns/1ns
`default_nettype none

module ifetch (
  input  logic        clk_in,
  input  logic        i_rst_n,
  input  logic        i_rdy,
  input  logic [7:0]  i_mem_din,
  output logic [31:0] o_mem_a,
  iq_if.src           q
);

  cpu_pkg::fetch_state_e fs;
  cpu_pkg::fetch_state_e fs_next;
  logic        pend;      // o_mem_a - 1 was issued on the last enabled edge
  logic        last_en;   // i_rdy of the previous cycle
  logic        take;
  logic        lost;
  logic        can_issue;
  logic [31:0] word;

  assign take      = pend && last_en;  // byte on i_mem_din belongs to pend
  assign lost      = pend && !last_en; // data has moved on during the freeze
  assign can_issue = o_mem_a < (`CPU_MEM_LIMIT - 32'd1);

  always_comb begin
    case (fs)
      cpu_pkg::FS_B0: fs_next = cpu_pkg::FS_B1;
      cpu_pkg::FS_B1: fs_next = cpu_pkg::FS_B2;
      cpu_pkg::FS_B2: fs_next = cpu_pkg::FS_B3;
      default:        fs_next = cpu_pkg::FS_PUSH;
    endcase
  end

  // tracks whether the address on the bus last cycle was really issued
  always_ff @(posedge clk_in) begin
    if (!i_rst_n) begin
      last_en <= 1'b0;
    end else begin
      last_en <= i_rdy;
    end
  end

  always_ff @(posedge clk_in) begin
    if (!i_rst_n) begin
      fs      <= cpu_pkg::FS_B0;
      o_mem_a <= `CPU_RESET_PC;
      pend    <= 1'b0;
    end else if (i_rdy) begin
      if (fs == cpu_pkg::FS_PUSH) begin
        if (q.ready) begin
          fs <= cpu_pkg::FS_B0;
          if (can_issue) begin  // byte 0 of the next word goes out now
            o_mem_a <= o_mem_a + 32'd1;
            pend    <= 1'b1;
          end
        end
      end else if (lost) begin
        o_mem_a <= o_mem_a - 32'd1; // step back and issue it again
        pend    <= 1'b0;
      end else begin
        if (take) begin
          fs <= fs_next;
        end
        if (take && fs == cpu_pkg::FS_B3) begin
          pend <= 1'b0; // word complete so wait for the queue
        end else if (can_issue) begin
          o_mem_a <= o_mem_a + 32'd1;
          pend    <= 1'b1;
        end else begin
          pend <= 1'b0;
        end
      end
    end
  end

  // lowest byte arrives first and ends up in [7:0]
  always_ff @(posedge clk_in) begin
    if (i_rdy && take) begin
      word <= {i_mem_din, word[31:8]};
    end
  end

  assign q.valid = (fs == cpu_pkg::FS_PUSH);
  assign q.instr = word;
  assign q.pc    = o_mem_a - 32'd4; // address sits just past the finished word

endmodule

`default_nettype wire

// File: rtl/inst_queue.sv
/* circular buffer of instruction words and their pc
   push on wr, pop on rd, both allowed in one cycle */
`include "cpu_settings.svh"
`timescale 1ns/1ns
`default_nettype none

module inst_queue (
  input  logic clk_in,
  input  logic i_rst_n,
  input  logic i_rdy,
  iq_if.dst    wr,
  iq_if.src    rd
);

  localparam int DEPTH = `CPU_IQ_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  logic [31:0] instr_mem [DEPTH];
  logic [31:0] pc_mem    [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic push;
  logic pop;

  assign push = wr.valid && wr.ready && i_rdy;
  assign pop  = rd.valid && rd.ready && i_rdy;

  always_ff @(posedge clk_in) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1; // wraps because depth is a power of two
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (push) begin
      instr_mem[wr_ptr] <= wr.instr;
      pc_mem[wr_ptr]    <= wr.pc;
    end
  end

  assign wr.ready = (count != DEPTH[AW:0]); // not full
  assign rd.valid = (count != '0);          // not empty
  assign rd.instr = instr_mem[rd_ptr];
  assign rd.pc    = pc_mem[rd_ptr];

endmodule

`default_nettype wire

// File: rtl/iq_if.sv
/* valid/ready link carrying an instruction word and its pc
   src is the writer, dst the reader */
`timescale 1ns/1ns
`default_nettype none

interface iq_if;

  logic        valid;
  logic [31:0] instr;
  logic [31:0] pc;
  logic        ready;

  modport src (
    output valid,
    output instr,
    output pc,
    input  ready
  );

  modport dst (
    input  valid,
    input  instr,
    input  pc,
    output ready
  );

endinterface

`default_nettype wire

// File: tests/cpu_asserts.sv
/* concurrent checks on fetch range, queue handshake and issue,
   attached to every cpu instance through the bind below */
`include "cpu_settings.svh"
`timescale 1ns/1ns
`default_nettype none

module cpu_asserts (
  input logic                           clk_in,
  input logic                           i_rst_n,
  input logic [31:0]                    i_mem_a,
  input logic                           i_fq_valid,
  input logic                           i_fq_ready,
  input cpu_pkg::fetch_state_e          i_fetch_state,
  input logic [$clog2(`CPU_IQ_DEPTH):0] i_iq_count
);

  mem_a_in_range: assert property (@(posedge clk_in) disable iff (!i_rst_n)
    i_mem_a < `CPU_MEM_LIMIT)
    else $error("fetch address %h past the end of memory", i_mem_a);

  // a word offered to a full queue stays offered
  fetch_word_held: assert property (@(posedge clk_in) disable iff (!i_rst_n)
    (i_fq_valid && !i_fq_ready) |=> (i_fq_valid && i_fetch_state == cpu_pkg::FS_PUSH))
    else $error("fetch dropped its word while the queue was full");

  // popping an empty queue would wrap the count below zero
  no_pop_when_empty: assert property (@(posedge clk_in) disable iff (!i_rst_n)
    (i_iq_count == '0) |=> (i_iq_count <= 1))
    else $error("execute popped an empty queue, count is now %0d", i_iq_count);

endmodule

bind cpu cpu_asserts u_asserts (
  .clk_in        (clk_in),
  .i_rst_n       (i_rst_n),
  .i_mem_a       (o_mem_a),
  .i_fq_valid    (fetch_q.valid),
  .i_fq_ready    (fetch_q.ready),
  .i_fetch_state (u_ifetch.fs),
  .i_iq_count    (u_queue.count)
);

`default_nettype wire

// File: tests/cpu_tb.sv
/* testbench for the cpu slice, runs the program from the data file twice,
   first with ready held high, then with ready dropping at random */
`include "cpu_settings.svh"
`timescale 1ns/1ns
`default_nettype none

module cpu_tb;

  localparam int TD_WORDS     = 64;
  localparam int MEM_BYTES    = `CPU_MEM_LIMIT;
  localparam int RUNS         = 2;
  localparam int STALL_CYCLES = 20;
  localparam int SETTLE       = 16 * `CPU_IQ_DEPTH; // enough to fill queue behind the halt

  logic        clk_in;
  logic        i_rst_n;
  logic        i_rdy;
  logic [7:0]  i_mem_din;
  logic [4:0]  i_dbg_sel;
  wire  [31:0] o_mem_a;
  wire  [31:0] o_now_pc;
  wire  [31:0] o_dbgreg_dout;

  logic [31:0] td [TD_WORDS]; // count, memory words, last pc, expected x0..x31
  bit   [7:0]  mem [MEM_BYTES];
  logic [31:0] addr_q;
  int          n_words;
  logic [31:0] last_pc;
  int          watchdog_cycles;
  integer      seed;

  tb_clock #(.PERIOD(4)) u_clock (.o_clk(clk_in));

  cpu dut (
    .clk_in        (clk_in),
    .i_rst_n       (i_rst_n),
    .i_rdy         (i_rdy),
    .i_mem_din     (i_mem_din),
    .i_dbg_sel     (i_dbg_sel),
    .o_mem_a       (o_mem_a),
    .o_now_pc      (o_now_pc),
    .o_dbgreg_dout (o_dbgreg_dout)
  );

  // the memory model takes the address mid-cycle and returns the byte after the next edge
  always @(negedge clk_in) begin
    addr_q = o_mem_a;
  end

  always @(posedge clk_in) begin
    #1;
    i_mem_din = (addr_q < MEM_BYTES) ? mem[addr_q[16:0]] : 8'h00;
  end

  task automatic abort_run();
    $display("test failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic load_program();
    $readmemh("tests/cpu_testdata.txt", td);
    assert (!$isunknown(td[0]) && td[0] + 34 <= TD_WORDS) else begin
      $display("data file tests/cpu_testdata.txt is missing or has a bad word count");
      abort_run();
    end
    n_words = td[0];
    for (int w = 0; w < n_words; w++) begin
      for (int b = 0; b < 4; b++) begin
        mem[4 * w + b] = td[1 + w][8 * b +: 8]; // little-endian
      end
    end
    last_pc = td[n_words + 1];
  endtask

  task automatic apply_reset();
    @(posedge clk_in);
    #1;
    i_rst_n = 1'b0;
    i_rdy   = 1'b0; // stays frozen after release for the reset checks
    repeat (5) @(posedge clk_in);
    #1;
    i_rst_n = 1'b1;
  endtask

  task automatic read_reg(input int idx, output logic [31:0] val);
    @(posedge clk_in);
    #1;
    i_dbg_sel = idx[4:0];
    @(negedge clk_in);
    val = o_dbgreg_dout;
  endtask

  task automatic check_reset_state();
    logic [31:0] val;
    for (int r = 0; r < 32; r++) begin
      read_reg(r, val);
      check_value($sformatf("x%0d after reset", r), val, 32'd0);
      check_value("o_mem_a after reset", o_mem_a, `CPU_RESET_PC);
      check_value("o_now_pc after reset", o_now_pc, 32'd0);
    end
  endtask

  task automatic wait_for_last_pc(input bit random_rdy);
    bit done;
    done = 1'b0;
    while (!done) begin
      @(posedge clk_in);
      #1;
      if (random_rdy) begin
        i_rdy = (($random(seed) & 3) != 0); // low about one cycle in four
      end else begin
        i_rdy = 1'b1;
      end
      @(negedge clk_in);
      done = (o_now_pc === last_pc);
    end
  endtask

  // x0 and the register written after the halt expect zero in the data file
  task automatic check_final_regs();
    logic [31:0] val;
    for (int r = 0; r < 32; r++) begin
      read_reg(r, val);
      check_value($sformatf("x%0d", r), val, td[n_words + 2 + r]);
    end
  endtask

  task automatic check_stall();
    logic [31:0] held_a;
    logic [31:0] held_pc;
    @(posedge clk_in);
    #1;
    i_rdy = 1'b1;
    repeat (SETTLE) @(posedge clk_in);
    @(negedge clk_in);
    held_a  = o_mem_a;
    held_pc = o_now_pc;
    check_value("o_now_pc at halt", held_pc, last_pc);
    repeat (STALL_CYCLES) begin
      @(negedge clk_in);
      check_value("o_mem_a after halt", o_mem_a, held_a);
      check_value("o_now_pc after halt", o_now_pc, held_pc);
    end
  endtask

  task automatic run_program(input bit random_rdy);
    $display("program run, random ready %0d", random_rdy);
    apply_reset();
    check_reset_state();
    wait_for_last_pc(random_rdy);
    check_final_regs();
    check_stall();
  endtask

  initial begin
    i_rst_n   = 1'b0;
    i_rdy     = 1'b0;
    i_mem_din = 8'h00;
    i_dbg_sel = 5'd0;
    addr_q    = 32'd0;
    seed      = 60343;
    load_program();
    watchdog_cycles = RUNS * (40 * n_words * 4 + 4 * 32 + SETTLE + 64);
    run_program(1'b0);
    run_program(1'b1);
    $display("test passed");
    $finish;
  end

  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk_in);
    $display("timeout, the program never finished within %0d cycles", watchdog_cycles);
    $display("test failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// File: tests/cpu_testdata.txt
// word count, then memory words from address 0 (halt and one word past it included),
// then the pc of the last retired instruction, then expected x0..x31 eight per line
0000000F
123450B7 // lui  x1, 0x12345
FFB00113 // addi x2, x0, -5
67808193 // addi x3, x1, 0x678
FFF1C213 // xori x4, x3, -1
1001E293 // ori  x5, x3, 0x100
0FF1F313 // andi x6, x3, 0xff
002183B3 // add  x7, x3, x2
40330433 // sub  x8, x6, x3
003244B3 // xor  x9, x4, x3
00136533 // or   x10, x6, x1
00A3F5B3 // and  x11, x7, x10
00118013 // addi x0, x3, 1
ABCDE037 // lui  x0, 0xabcde
00000000 // halt
12300613 // addi x12, x0, 0x123, never retired
00000030 // pc of the last instruction
00000000 12345000 FFFFFFFB 12345678 EDCBA987 12345778 00000078 12345673
EDCBAA00 FFFFFFFF 12345078 12345070 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000

// File: tests/tb_clock.sv
/* free-running testbench clock, period given in ns */
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
  parameter int PERIOD = 4
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
    forever begin
      #(PERIOD / 2) o_clk = ~o_clk; // half period high, half low
    end
  end

endmodule

`default_nettype wire
